// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module ext_periph_tb \
		-f flist.f --Mdir obj_dir -o ext_periph_sim
	./obj_dir/ext_periph_sim +verilator+error+limit+1000 | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/ext_periph_sva.sv ====
/*
 * Protocol assertions for the external peripheral subsystem
 * Register bus latency, memory master handshake, interrupt and zero size copy
 */
`timescale 1ns/1ps

module ext_periph_sva (
  input logic                     clk_i,
  input logic                     reset_i,
  input ext_periph_pkg::reg_req_t reg_req_i,
  input ext_periph_pkg::reg_rsp_t reg_rsp_i,
  input ext_periph_pkg::obi_req_t obi_req_i,
  input ext_periph_pkg::obi_rsp_t obi_rsp_i,
  input logic                     start_i,
  input logic [31:0]              size_i,
  input logic                     done_i,
  input logic                     intr_i
);

  localparam logic [31:0] STATUS_ADDR =
    ext_periph_pkg::MEMCOPY_BASE | {27'd0, ext_periph_pkg::REG_STATUS, 2'b00};

  int         fail_cnt = 0;
  logic [2:0] wait_q;
  logic       done_clr;
  logic       done_flag_q;

  // Cycles a register bus request has waited so far
  always_ff @(posedge clk_i) begin
    if (reset_i || !reg_req_i.valid || reg_rsp_i.ready) begin
      wait_q <= '0;
    end else if (wait_q != 3'd7) begin
      wait_q <= wait_q + 3'd1;
    end
  end

  // Write of 1 to the done bit on a completed status transfer
  assign done_clr = reg_req_i.valid && reg_rsp_i.ready && reg_req_i.write &&
                    (reg_req_i.addr == STATUS_ADDR) && reg_req_i.wdata[1];

  // Sticky done flag rebuilt from the done pulse, start and status writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_flag_q <= 1'b0;
    end else if (done_i) begin
      done_flag_q <= 1'b1;
    end else if (start_i || done_clr) begin
      done_flag_q <= 1'b0;
    end
  end

  a_reg_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    reg_req_i.valid |-> wait_q <= 3'd2)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("register bus valid waited more than 2 cycles for ready");
    end

  a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_req_i.req && !obi_rsp_i.gnt |=> obi_req_i.req && $stable(obi_req_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("memory request dropped or changed before grant");
    end

  a_gnt_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_rsp_i.gnt |=> obi_rsp_i.rvalid && !obi_req_i.req)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("grant not followed by rvalid, or request raised while outstanding");
    end

  a_rvalid_once: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_rsp_i.rvalid |-> $past(obi_rsp_i.gnt))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("rvalid without a grant in the previous cycle");
    end

  a_intr_done: assert property (@(posedge clk_i) disable iff (reset_i)
    intr_i |-> done_flag_q)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("interrupt high while the done flag is clear");
    end

  a_zero_size: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i && size_i == '0 |=> done_i && !obi_req_i.req)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("zero size copy issued a memory request or missed the done pulse");
    end

endmodule

bind ext_periph_top ext_periph_sva u_sva (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .reg_req_i (reg_req_i),
  .reg_rsp_i (reg_rsp_o),
  .obi_req_i (obi_req),
  .obi_rsp_i (obi_rsp),
  .start_i   (start),
  .size_i    (size),
  .done_i    (done),
  .intr_i    (intr_o)
);

// ==== dv/ext_periph_tb.sv ====
/*
 * External peripheral subsystem testbench
 * Register access, memcopy runs, status, interrupt gating and window contention
 */
`timescale 1ns/1ps

module ext_periph_tb;

  localparam int TOTAL_WORDS     = 16 + 4 + 0 + 32;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 2000;

  logic                     clk;
  logic                     reset;
  ext_periph_pkg::reg_req_t reg_req;
  ext_periph_pkg::reg_rsp_t reg_rsp;
  logic                     intr;

  int          data_errs;
  int          proto_errs;
  int          total_errs;
  logic        gate_check;
  logic        err;
  logic [31:0] rdata;
  logic [31:0] src_data [32];

  ext_periph_top #(
    .NUM_WORDS (256)
  ) u_dut (
    .clk_i     (clk),
    .reset_i   (reset),
    .reg_req_i (reg_req),
    .reg_rsp_o (reg_rsp),
    .intr_o    (intr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] reg_addr(input ext_periph_pkg::memcopy_reg_e r);
    return ext_periph_pkg::MEMCOPY_BASE | {27'd0, r, 2'b00};
  endfunction

  function automatic logic [31:0] mem_addr(input int word);
    return ext_periph_pkg::MEM_BASE | (32'(word) << 2);
  endfunction

  task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rd, output logic er);
    int   waits;
    logic fin;
    waits = 0;
    fin   = 1'b0;
    rd    = '0;
    er    = 1'b1;
    @(posedge clk);
    #2;
    reg_req.valid = 1'b1;
    reg_req.write = wr;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    while (!fin) begin
      @(negedge clk);
      if (reg_rsp.ready) begin
        rd  = reg_rsp.rdata;
        er  = reg_rsp.error;
        fin = 1'b1;
      end else if (waits == 10) begin
        proto_errs++;
        $display("Register bus transfer to 0x%08h never received ready", addr);
        fin = 1'b1;
      end else begin
        waits++;
      end
      @(posedge clk);
    end
    #2;
    reg_req = '0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      data_errs++;
      $display("FAIL %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    logic        er;
    bus_xfer(1'b1, addr, wdata, unused, er);
    check_value("write error flag", {31'd0, er}, 32'd0);
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] rd);
    logic er;
    bus_xfer(1'b0, addr, '0, rd, er);
    check_value("read error flag", {31'd0, er}, 32'd0);
  endtask

  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] words);
    reg_write(reg_addr(ext_periph_pkg::REG_SRC_PTR), src);
    reg_write(reg_addr(ext_periph_pkg::REG_DST_PTR), dst);
    reg_write(reg_addr(ext_periph_pkg::REG_SIZE), words);
    reg_write(reg_addr(ext_periph_pkg::REG_START), 32'd1);
  endtask

  task automatic wait_for_intr(input int limit);
    int n;
    n = 0;
    while (!intr && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (intr) else begin
      proto_errs++;
      $display("Interrupt did not arrive within %0d cycles", limit);
    end
  endtask

  task automatic wait_for_done(input int limit);
    int          n;
    logic [31:0] st;
    n  = 0;
    st = '0;
    while (!st[1] && n < limit) begin
      reg_read(reg_addr(ext_periph_pkg::REG_STATUS), st);
      n++;
    end
    assert (st[1]) else begin
      proto_errs++;
      $display("Done flag did not set after %0d status polls", limit);
    end
  endtask

  // Interrupt must stay low while gating is under test
  always @(negedge clk) begin
    if (gate_check) begin
      assert (!intr) else begin
        data_errs++;
        $display("FAIL %0t: intr_o high while the interrupt enable is clear", $time);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(1));
    reg_req    = '0;
    reset      = 1'b1;
    data_errs  = 0;
    proto_errs = 0;
    gate_check = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    // Register readback and unmapped access
    reg_write(reg_addr(ext_periph_pkg::REG_SRC_PTR), 32'h1234_5678);
    reg_write(reg_addr(ext_periph_pkg::REG_DST_PTR), 32'hCAFE_0004);
    reg_write(reg_addr(ext_periph_pkg::REG_SIZE), 32'h0000_0ABC);
    reg_write(reg_addr(ext_periph_pkg::REG_INTR_EN), 32'd1);
    reg_read(reg_addr(ext_periph_pkg::REG_SRC_PTR), rdata);
    check_value("SRC_PTR", rdata, 32'h1234_5678);
    reg_read(reg_addr(ext_periph_pkg::REG_DST_PTR), rdata);
    check_value("DST_PTR", rdata, 32'hCAFE_0004);
    reg_read(reg_addr(ext_periph_pkg::REG_SIZE), rdata);
    check_value("SIZE", rdata, 32'h0000_0ABC);
    reg_read(reg_addr(ext_periph_pkg::REG_INTR_EN), rdata);
    check_value("INTR_EN", rdata, 32'd1);
    reg_read(reg_addr(ext_periph_pkg::REG_START), rdata);
    check_value("START", rdata, 32'd0);
    bus_xfer(1'b0, 32'h0002_0000, '0, rdata, err);
    check_value("unmapped error flag", {31'd0, err}, 32'd1);

    // 16 word copy to 0x200
    for (int i = 0; i < 16; i++) begin
      src_data[i] = $urandom();
      reg_write(mem_addr(i), src_data[i]);
    end
    start_copy(32'h0, 32'h200, 32'd16);
    reg_read(reg_addr(ext_periph_pkg::REG_STATUS), rdata);
    check_value("STATUS while busy", rdata, 32'h1);
    wait_for_intr(16 * 20 + 100);
    for (int i = 0; i < 16; i++) begin
      reg_read(mem_addr(128 + i), rdata);
      check_value("copy destination", rdata, src_data[i]);
      reg_read(mem_addr(i), rdata);
      check_value("copy source", rdata, src_data[i]);
    end

    // Status after the copy and done clear
    reg_read(reg_addr(ext_periph_pkg::REG_STATUS), rdata);
    check_value("STATUS after copy", rdata, 32'h2);
    reg_write(reg_addr(ext_periph_pkg::REG_STATUS), 32'h2);
    check_value("intr_o after clear", {31'd0, intr}, 32'd0);
    reg_read(reg_addr(ext_periph_pkg::REG_STATUS), rdata);
    check_value("STATUS after clear", rdata, 32'h0);

    // Gated interrupt on a 4 word copy
    reg_write(reg_addr(ext_periph_pkg::REG_INTR_EN), 32'd0);
    gate_check = 1'b1;
    start_copy(32'h0, 32'h300, 32'd4);
    wait_for_done(4 * 20 + 100);
    gate_check = 1'b0;
    for (int i = 0; i < 4; i++) begin
      reg_read(mem_addr(192 + i), rdata);
      check_value("gated copy destination", rdata, src_data[i]);
    end
    reg_write(reg_addr(ext_periph_pkg::REG_INTR_EN), 32'd1);
    check_value("intr_o after enable", {31'd0, intr}, 32'd1);
    reg_write(reg_addr(ext_periph_pkg::REG_STATUS), 32'h2);

    // Zero size start leaves memory alone
    reg_write(mem_addr(224), 32'hA5A5_0F0F);
    start_copy(32'h0, 32'h380, 32'd0);
    wait_for_done(100);
    reg_read(mem_addr(224), rdata);
    check_value("zero size destination", rdata, 32'hA5A5_0F0F);
    reg_write(reg_addr(ext_periph_pkg::REG_STATUS), 32'h2);

    // Window reads during a 32 word copy
    for (int i = 0; i < 32; i++) begin
      src_data[i] = $urandom();
      reg_write(mem_addr(32 + i), src_data[i]);
    end
    start_copy(32'h80, 32'h280, 32'd32);
    for (int i = 0; i < 32; i++) begin
      reg_read(mem_addr(32 + i), rdata);
      check_value("window read during copy", rdata, src_data[i]);
    end
    wait_for_intr(32 * 20 + 100);
    for (int i = 0; i < 32; i++) begin
      reg_read(mem_addr(160 + i), rdata);
      check_value("contended copy destination", rdata, src_data[i]);
    end

    repeat (5) @(posedge clk);
    total_errs = data_errs + proto_errs + u_dut.u_sva.fail_cnt;
    $display("Errors: data %0d, protocol %0d, assertion %0d",
             data_errs, proto_errs, u_dut.u_sva.fail_cnt);
    if (total_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/ext_periph_pkg.sv
hdl/ext_periph_decode.sv
hdl/memcopy_regs.sv
hdl/memcopy_engine.sv
hdl/slow_memory.sv
hdl/ext_periph_top.sv
dv/ext_periph_sva.sv
dv/ext_periph_tb.sv

// ==== hdl/ext_periph_decode.sv ====
/*
 * Register bus decoder and demux
 * Steers one slave port to the DMA registers or the memory window and errors elsewhere
 */
`timescale 1ns/1ps

module ext_periph_decode (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  ext_periph_pkg::reg_req_t req_i,
  output ext_periph_pkg::reg_rsp_t rsp_o,
  output ext_periph_pkg::reg_req_t regs_req_o,
  output ext_periph_pkg::reg_req_t mem_req_o,
  input  ext_periph_pkg::reg_rsp_t regs_rsp_i,
  input  ext_periph_pkg::reg_rsp_t mem_rsp_i
);

  logic [31:0]                 base;
  logic                        hit;
  logic                        sel_hit;
  logic                        pend_q;
  ext_periph_pkg::periph_idx_e dec_idx;
  ext_periph_pkg::periph_idx_e sel_idx;
  ext_periph_pkg::periph_idx_e idx_q;
  ext_periph_pkg::reg_req_t    fwd_req;

  assign base = req_i.addr & ~ext_periph_pkg::WINDOW_MASK;

  always_comb begin
    hit     = 1'b1;
    dec_idx = ext_periph_pkg::PERIPH_MEMCOPY;
    if (base == ext_periph_pkg::MEM_BASE) begin
      dec_idx = ext_periph_pkg::PERIPH_MEM;
    end else if (base != ext_periph_pkg::MEMCOPY_BASE) begin
      hit = 1'b0;
    end
  end

  // Hold the target while a transfer waits for ready
  assign sel_idx = pend_q ? idx_q : dec_idx;
  assign sel_hit = pend_q | hit;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q <= 1'b0;
      idx_q  <= ext_periph_pkg::PERIPH_MEMCOPY;
    end else if (pend_q) begin
      if (rsp_o.ready) pend_q <= 1'b0;
    end else if (req_i.valid && hit && !rsp_o.ready) begin
      pend_q <= 1'b1;
      idx_q  <= dec_idx;
    end
  end

  // Targets see the offset inside their window
  always_comb begin
    fwd_req      = req_i;
    fwd_req.addr = req_i.addr & ext_periph_pkg::WINDOW_MASK;

    regs_req_o       = fwd_req;
    regs_req_o.valid = req_i.valid & sel_hit & (sel_idx == ext_periph_pkg::PERIPH_MEMCOPY);
    mem_req_o        = fwd_req;
    mem_req_o.valid  = req_i.valid & sel_hit & (sel_idx == ext_periph_pkg::PERIPH_MEM);
  end

  always_comb begin
    rsp_o = '0;
    if (!sel_hit) begin
      // Unmapped address answers at once
      rsp_o.ready = req_i.valid;
      rsp_o.error = req_i.valid;
    end else if (sel_idx == ext_periph_pkg::PERIPH_MEM) begin
      rsp_o = mem_rsp_i;
    end else begin
      rsp_o = regs_rsp_i;
    end
  end

endmodule

// ==== hdl/ext_periph_pkg.sv ====
/*
 * External peripheral subsystem shared types
 * Register bus and memory master bundles, register map, address windows, engine states
 */
package ext_periph_pkg;

  // Register bus request and response
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Memory master request and response
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_rsp_t;

  typedef enum logic [0:0] {
    PERIPH_MEMCOPY = 1'b0,
    PERIPH_MEM     = 1'b1
  } periph_idx_e;

  // Word offsets taken from addr[4:2]
  typedef enum logic [2:0] {
    REG_SRC_PTR = 3'd0,
    REG_DST_PTR = 3'd1,
    REG_SIZE    = 3'd2,
    REG_START   = 3'd3,
    REG_STATUS  = 3'd4,
    REG_INTR_EN = 3'd5
  } memcopy_reg_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_WR_REQ,
    ST_WR_WAIT,
    ST_DONE
  } engine_state_e;

  localparam logic [31:0] MEMCOPY_BASE = 32'h0000_0000;
  localparam logic [31:0] MEM_BASE     = 32'h0001_0000;
  localparam logic [31:0] WINDOW_MASK  = 32'h0000_FFFF;

endpackage

// ==== hdl/ext_periph_top.sv ====
/*
 * External peripheral subsystem top level
 * Decoder, memcopy DMA and slow memory behind one register bus port
 */
`timescale 1ns/1ps

module ext_periph_top #(
  parameter int NUM_WORDS = 256
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  ext_periph_pkg::reg_req_t reg_req_i,
  output ext_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                     intr_o
);

  ext_periph_pkg::reg_req_t regs_req;
  ext_periph_pkg::reg_rsp_t regs_rsp;
  ext_periph_pkg::reg_req_t mem_req;
  ext_periph_pkg::reg_rsp_t mem_rsp;
  ext_periph_pkg::obi_req_t obi_req;
  ext_periph_pkg::obi_rsp_t obi_rsp;

  logic [31:0] src_ptr;
  logic [31:0] dst_ptr;
  logic [31:0] size;
  logic        start;
  logic        busy;
  logic        done;

  ext_periph_decode u_decode (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (reg_req_i),
    .rsp_o      (reg_rsp_o),
    .regs_req_o (regs_req),
    .mem_req_o  (mem_req),
    .regs_rsp_i (regs_rsp),
    .mem_rsp_i  (mem_rsp)
  );

  memcopy_regs u_regs (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (regs_req),
    .rsp_o     (regs_rsp),
    .src_ptr_o (src_ptr),
    .dst_ptr_o (dst_ptr),
    .size_o    (size),
    .start_o   (start),
    .busy_i    (busy),
    .done_i    (done),
    .intr_o    (intr_o)
  );

  memcopy_engine u_engine (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .src_ptr_i (src_ptr),
    .dst_ptr_i (dst_ptr),
    .size_i    (size),
    .start_i   (start),
    .busy_o    (busy),
    .done_o    (done),
    .obi_req_o (obi_req),
    .obi_rsp_i (obi_rsp)
  );

  slow_memory #(
    .NUM_WORDS (NUM_WORDS)
  ) u_mem (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .obi_req_i (obi_req),
    .obi_rsp_o (obi_rsp),
    .win_req_i (mem_req),
    .win_rsp_o (mem_rsp)
  );

endmodule

// ==== hdl/memcopy_engine.sv ====
/*
 * Memcopy copy engine
 * Word by word read then write over the memory master port
 */
`timescale 1ns/1ps

module memcopy_engine (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [31:0]              src_ptr_i,
  input  logic [31:0]              dst_ptr_i,
  input  logic [31:0]              size_i,
  input  logic                     start_i,
  output logic                     busy_o,
  output logic                     done_o,
  output ext_periph_pkg::obi_req_t obi_req_o,
  input  ext_periph_pkg::obi_rsp_t obi_rsp_i
);

  ext_periph_pkg::engine_state_e state_q;
  ext_periph_pkg::engine_state_e state_d;

  logic [31:0] cnt_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] data_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ext_periph_pkg::ST_IDLE: begin
        if (start_i) begin
          state_d = (size_i == '0) ? ext_periph_pkg::ST_DONE : ext_periph_pkg::ST_RD_REQ;
        end
      end
      ext_periph_pkg::ST_RD_REQ: begin
        if (obi_rsp_i.gnt) state_d = ext_periph_pkg::ST_RD_WAIT;
      end
      ext_periph_pkg::ST_RD_WAIT: begin
        if (obi_rsp_i.rvalid) state_d = ext_periph_pkg::ST_WR_REQ;
      end
      ext_periph_pkg::ST_WR_REQ: begin
        if (obi_rsp_i.gnt) state_d = ext_periph_pkg::ST_WR_WAIT;
      end
      ext_periph_pkg::ST_WR_WAIT: begin
        if (obi_rsp_i.rvalid) begin
          // Last word written
          state_d = (cnt_q == 32'd1) ? ext_periph_pkg::ST_DONE : ext_periph_pkg::ST_RD_REQ;
        end
      end
      ext_periph_pkg::ST_DONE: state_d = ext_periph_pkg::ST_IDLE;
      default: state_d = ext_periph_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ext_periph_pkg::ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ext_periph_pkg::ST_IDLE && start_i) begin
        cnt_q <= size_i;
      end else if (state_q == ext_periph_pkg::ST_WR_WAIT && obi_rsp_i.rvalid) begin
        cnt_q <= cnt_q - 32'd1;
      end
    end
  end

  // Pointers step one word per completed write
  always_ff @(posedge clk_i) begin
    if (state_q == ext_periph_pkg::ST_IDLE && start_i) begin
      src_q <= src_ptr_i;
      dst_q <= dst_ptr_i;
    end else if (state_q == ext_periph_pkg::ST_WR_WAIT && obi_rsp_i.rvalid) begin
      src_q <= src_q + 32'd4;
      dst_q <= dst_q + 32'd4;
    end
    if (state_q == ext_periph_pkg::ST_RD_WAIT && obi_rsp_i.rvalid) begin
      data_q <= obi_rsp_i.rdata;
    end
  end

  always_comb begin
    obi_req_o       = '0;
    obi_req_o.req   = (state_q == ext_periph_pkg::ST_RD_REQ) ||
                      (state_q == ext_periph_pkg::ST_WR_REQ);
    obi_req_o.we    = (state_q == ext_periph_pkg::ST_WR_REQ);
    obi_req_o.addr  = obi_req_o.we ? dst_q : src_q;
    obi_req_o.wdata = data_q;
  end

  assign busy_o = (state_q != ext_periph_pkg::ST_IDLE);
  assign done_o = (state_q == ext_periph_pkg::ST_DONE);

endmodule

// ==== hdl/memcopy_regs.sv ====
/*
 * Memcopy DMA register block
 * Configuration, start pulse, sticky done flag and level interrupt
 */
`timescale 1ns/1ps

module memcopy_regs (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  ext_periph_pkg::reg_req_t req_i,
  output ext_periph_pkg::reg_rsp_t rsp_o,
  output logic [31:0]              src_ptr_o,
  output logic [31:0]              dst_ptr_o,
  output logic [31:0]              size_o,
  output logic                     start_o,
  input  logic                     busy_i,
  input  logic                     done_i,
  output logic                     intr_o
);

  ext_periph_pkg::memcopy_reg_e offset;
  logic        reg_hit;
  logic        wr_en;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] size_q;
  logic        intr_en_q;
  logic        done_q;

  assign offset = ext_periph_pkg::memcopy_reg_e'(req_i.addr[4:2]);

  // Only the first six words are decoded
  assign reg_hit = (req_i.addr[31:5] == '0) && (req_i.addr[4:2] <= 3'd5);
  assign wr_en   = req_i.valid & req_i.write & reg_hit;

  assign start_o = wr_en & (offset == ext_periph_pkg::REG_START) & ~busy_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q     <= '0;
      dst_q     <= '0;
      size_q    <= '0;
      intr_en_q <= 1'b0;
    end else if (wr_en) begin
      case (offset)
        ext_periph_pkg::REG_SRC_PTR: src_q     <= req_i.wdata;
        ext_periph_pkg::REG_DST_PTR: dst_q     <= req_i.wdata;
        ext_periph_pkg::REG_SIZE:    size_q    <= req_i.wdata;
        ext_periph_pkg::REG_INTR_EN: intr_en_q <= req_i.wdata[0];
        default: ;
      endcase
    end
  end

  // Done pulse wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end else if (start_o) begin
      done_q <= 1'b0;
    end else if (wr_en && offset == ext_periph_pkg::REG_STATUS && req_i.wdata[1]) begin
      done_q <= 1'b0;
    end
  end

  always_comb begin
    rsp_o       = '0;
    rsp_o.ready = req_i.valid;
    rsp_o.error = req_i.valid & ~reg_hit;
    if (req_i.valid && reg_hit) begin
      case (offset)
        ext_periph_pkg::REG_SRC_PTR: rsp_o.rdata = src_q;
        ext_periph_pkg::REG_DST_PTR: rsp_o.rdata = dst_q;
        ext_periph_pkg::REG_SIZE:    rsp_o.rdata = size_q;
        ext_periph_pkg::REG_STATUS:  rsp_o.rdata = {30'b0, done_q, busy_i};
        ext_periph_pkg::REG_INTR_EN: rsp_o.rdata = {31'b0, intr_en_q};
        default:                     rsp_o.rdata = '0;
      endcase
    end
  end

  assign src_ptr_o = src_q;
  assign dst_ptr_o = dst_q;
  assign size_o    = size_q;
  assign intr_o    = done_q & intr_en_q;

endmodule

// ==== hdl/slow_memory.sv ====
/*
 * Slow word memory
 * Master port with random grant delay plus a register bus window with priority
 */
`timescale 1ns/1ps

module slow_memory #(
  parameter int NUM_WORDS = 256
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  ext_periph_pkg::obi_req_t obi_req_i,
  output ext_periph_pkg::obi_rsp_t obi_rsp_o,
  input  ext_periph_pkg::reg_req_t win_req_i,
  output ext_periph_pkg::reg_rsp_t win_rsp_o
);

  localparam int IDX_W = $clog2(NUM_WORDS);

  logic [31:0]      mem [NUM_WORDS];
  logic [IDX_W-1:0] obi_idx;
  logic [IDX_W-1:0] win_idx;
  logic [7:0]       lfsr_q;
  logic             wait_act_q;
  logic [1:0]       wait_cnt_q;
  logic [1:0]       cur_cnt;
  logic             gnt;
  logic             rvalid_q;
  logic [31:0]      obi_rdata_q;
  logic             win_pend_q;
  logic [31:0]      win_rdata_q;

  assign obi_idx = obi_req_i.addr[IDX_W+1:2];
  assign win_idx = win_req_i.addr[IDX_W+1:2];

  // Wait count comes from the LFSR when a request first shows up
  assign cur_cnt = wait_act_q ? wait_cnt_q : lfsr_q[1:0];
  assign gnt     = obi_req_i.req & (cur_cnt == 2'd0) & ~win_req_i.valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_q     <= 8'hA5;
      wait_act_q <= 1'b0;
      wait_cnt_q <= '0;
      rvalid_q   <= 1'b0;
      win_pend_q <= 1'b0;
    end else begin
      lfsr_q   <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      rvalid_q <= gnt;
      if (gnt) begin
        wait_act_q <= 1'b0;
      end else if (obi_req_i.req) begin
        wait_act_q <= 1'b1;
        wait_cnt_q <= (cur_cnt == 2'd0) ? 2'd0 : cur_cnt - 2'd1;
      end
      win_pend_q <= win_req_i.valid & ~win_pend_q;
    end
  end

  // Window access happens in its first cycle while gnt is low
  always_ff @(posedge clk_i) begin
    if (win_req_i.valid && !win_pend_q) begin
      if (win_req_i.write) mem[win_idx] <= win_req_i.wdata;
      win_rdata_q <= mem[win_idx];
    end else if (gnt) begin
      if (obi_req_i.we) mem[obi_idx] <= obi_req_i.wdata;
      obi_rdata_q <= mem[obi_idx];
    end
  end

  always_comb begin
    obi_rsp_o        = '0;
    obi_rsp_o.gnt    = gnt;
    obi_rsp_o.rvalid = rvalid_q;
    obi_rsp_o.rdata  = obi_rdata_q;
    win_rsp_o        = '0;
    win_rsp_o.ready  = win_pend_q;
    win_rsp_o.rdata  = win_rdata_q;
  end

endmodule
